//--- verilog/emesh_pkg.sv
// eMesh packet definitions
// Packet layout and the channel bundle (access plus packet) that is
// shared by the FIFOs, the arbiter and the transmit top level

package emesh_pkg;

   //####################################################################
   // Sizes
   //####################################################################

   // Full packet width on every channel
   localparam int PW         = 104;

   // Entries per channel FIFO and pointer width
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_AW    = 2;

   //####################################################################
   // Packet layout, top bit down
   //####################################################################

   typedef struct packed {
      logic [31:0] srcaddr;      // Return address for reads
      logic [31:0] data;
      logic [31:0] dstaddr;
      logic        reserved;     // Old bit 7, cleared on host traffic
      logic [3:0]  ctrlmode;     // Bits 6 to 3
      logic [1:0]  datamode;
      logic        write;
   } emesh_packet_t;

   // One channel link
   // Access qualifies the packet for the current cycle
   typedef struct packed {
      logic          access;
      emesh_packet_t packet;
   } emesh_chan_t;

endpackage

//--- verilog/etx_cfg_pkg.sv
// Transmit configuration definitions
// APB request and response bundles, register map of the transmit
// register block and the configuration handed to the arbiter

package etx_cfg_pkg;

   // APB address width
   localparam int APB_AW = 8;

   //####################################################################
   // APB bundles
   //####################################################################

   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [APB_AW-1:0] paddr;
      logic [31:0]       pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   //####################################################################
   // Register map
   //####################################################################

   // Control: bit 0 enable, bit 1 bypass, bits 7:4 ctrlmode
   localparam logic [APB_AW-1:0] ETX_CTRL_ADDR   = 8'h00;
   // Status: sent packet count, read only
   localparam logic [APB_AW-1:0] ETX_STATUS_ADDR = 8'h04;

   // Fields consumed by the arbiter
   typedef struct packed {
      logic       tx_enable;
      logic       ctrlmode_bypass;
      logic [3:0] ctrlmode;
   } etx_cfg_t;

endpackage

//--- verilog/etx_fifo.sv
// Transmit channel FIFO
// First-word-fall-through buffer with access/wait on both sides.
// A new entry becomes visible at the head one cycle after its push

module etx_fifo
   import emesh_pkg::*;
(
   input  logic        clk,
   input  logic        nreset,
   input  emesh_chan_t in,
   output logic        in_wait,
   output emesh_chan_t out,
   input  logic        out_wait
);

   // Packet storage
   emesh_packet_t      mem [FIFO_DEPTH];

   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   // Occupancy including the entry pushed last cycle
   logic [FIFO_AW:0]   count;
   // Push of the previous cycle, not yet visible
   logic               push_q;
   logic [FIFO_AW:0]   visible;
   logic               head_valid;
   logic               push;
   logic               pop;

   //####################################################################
   // Handshakes
   //####################################################################

   // Wait exactly while full
   assign in_wait    = (count == (FIFO_AW+1)'(FIFO_DEPTH));
   assign push       = in.access & ~in_wait;

   // Hide the newest entry for one cycle
   assign visible    = count - {{FIFO_AW{1'b0}}, push_q};
   assign head_valid = (visible != '0);
   assign pop        = head_valid & ~out_wait;

   assign out = '{access: head_valid, packet: mem[rd_ptr]};

   //####################################################################
   // Storage and pointers
   //####################################################################

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= in.packet;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         push_q <= 1'b0;
      end
      else
      begin
         push_q <= push;
         // Pointers wrap naturally at depth 4
         if (push)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Never more entries than slots
   a_no_overflow: assert property (@(posedge clk) disable iff (!nreset)
      count <= (FIFO_AW+1)'(FIFO_DEPTH));

   // Pop only with a stored entry
   a_no_underflow: assert property (@(posedge clk) disable iff (!nreset)
      pop |-> count != '0);

endmodule

//--- verilog/etx_arbiter.sv
// Transmit arbiter
// Fixed priority between host writes, host read requests and read
// responses, ctrlmode splicing on host traffic and one output
// pipeline stage that holds under pin wait

module etx_arbiter
   import emesh_pkg::*;
   import etx_cfg_pkg::*;
(
   input  logic        clk,
   input  logic        nreset,
   input  emesh_chan_t txwr,
   input  emesh_chan_t txrd,
   input  emesh_chan_t txrr,
   output logic        txwr_wait,
   output logic        txrd_wait,
   output logic        txrr_wait,
   input  etx_cfg_t    cfg,
   input  logic        etx_wr_wait,
   input  logic        etx_rd_wait,
   output emesh_chan_t etx_out,
   output logic        etx_rr
);

   logic          pin_wait;
   logic          cfg_wait;
   logic          wr_grant;
   logic          rd_grant;
   logic          rr_grant;
   logic          access_in;
   logic          rr_in;
   emesh_packet_t wr_splice;
   emesh_packet_t rd_splice;
   emesh_packet_t mux_packet;
   logic          out_access;
   logic          out_rr;
   emesh_packet_t out_packet;

   // Host packet rewrite
   // Reserved bit always cleared, ctrlmode replaced only under bypass
   function automatic emesh_packet_t splice(emesh_packet_t pkt, etx_cfg_t c);
      emesh_packet_t res;
      res          = pkt;
      res.reserved = 1'b0;
      if (c.ctrlmode_bypass)
      begin
         res.ctrlmode = c.ctrlmode;
      end
      return res;
   endfunction

   assign wr_splice = splice(txwr.packet, cfg);
   assign rd_splice = splice(txrd.packet, cfg);

   //####################################################################
   // Priority chain and mux
   //####################################################################

   // Write first, then read request, then read response
   assign wr_grant = txwr.access;
   assign rd_grant = txrd.access & ~txwr.access;
   assign rr_grant = txrr.access & ~txwr.access & ~txrd.access;

   assign mux_packet = emesh_packet_t'(({PW{wr_grant}} & wr_splice) |
                                       ({PW{rd_grant}} & rd_splice) |
                                       ({PW{rr_grant}} & txrr.packet));

   //####################################################################
   // Wait generation
   //####################################################################

   // Disabled transmitter stalls everything
   assign cfg_wait = ~cfg.tx_enable;
   assign pin_wait = etx_wr_wait | etx_rd_wait;

   // Lower channels also wait while a higher one is present
   assign txwr_wait = pin_wait | cfg_wait;
   assign txrd_wait = pin_wait | cfg_wait | txwr.access;
   assign txrr_wait = pin_wait | cfg_wait | txwr.access | txrd.access;

   // Captured channel is the one popped from its FIFO
   assign access_in = (wr_grant & ~txwr_wait) |
                      (rd_grant & ~txrd_wait) |
                      (rr_grant & ~txrr_wait);
   assign rr_in     = rr_grant & ~txrr_wait;

   //####################################################################
   // Output pipeline stage
   //####################################################################

   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         out_access <= 1'b0;
         out_rr     <= 1'b0;
      end
      else if (!pin_wait)
      begin
         out_access <= access_in;
         out_rr     <= rr_in;
      end
   end

   // access_in already excludes pin wait
   always_ff @(posedge clk)
   begin
      if (access_in)
      begin
         out_packet <= mux_packet;
      end
   end

   assign etx_out = '{access: out_access, packet: out_packet};
   assign etx_rr  = out_rr;

   a_one_grant: assert property (@(posedge clk) disable iff (!nreset)
      $onehot0({wr_grant, rd_grant, rr_grant}));

   a_rr_access: assert property (@(posedge clk) disable iff (!nreset)
      etx_rr |-> etx_out.access);

endmodule

//--- verilog/etx_cfg.sv
// Transmit register block
// Zero-wait APB slave with the control register (enable, bypass,
// ctrlmode) and a wrapping count of packets sent on the pins

module etx_cfg
   import etx_cfg_pkg::*;
(
   input  logic     clk,
   input  logic     nreset,
   input  apb_req_t apb_req,
   output apb_rsp_t apb_rsp,
   input  logic     etx_sent,
   output etx_cfg_t cfg
);

   logic        access_phase;
   logic        wr_en;
   logic        sel_ctrl;
   logic        sel_status;
   logic        bad_addr;
   etx_cfg_t    ctrl_q;
   logic [15:0] sent_count;
   logic [31:0] rdata;

   //####################################################################
   // Decode
   //####################################################################

   assign access_phase = apb_req.psel & apb_req.penable;
   assign wr_en        = access_phase & apb_req.pwrite;

   assign sel_ctrl   = (apb_req.paddr == ETX_CTRL_ADDR);
   assign sel_status = (apb_req.paddr == ETX_STATUS_ADDR);
   assign bad_addr   = ~sel_ctrl & ~sel_status;

   //####################################################################
   // Registers
   //####################################################################

   // Enabled, no bypass out of reset
   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         ctrl_q <= '{tx_enable: 1'b1, ctrlmode_bypass: 1'b0, ctrlmode: 4'h0};
      end
      else if (wr_en && sel_ctrl)
      begin
         ctrl_q.tx_enable       <= apb_req.pwdata[0];
         ctrl_q.ctrlmode_bypass <= apb_req.pwdata[1];
         ctrl_q.ctrlmode        <= apb_req.pwdata[7:4];
      end
   end

   // Sent packets, wraps at 16 bits
   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         sent_count <= '0;
      end
      else if (etx_sent)
      begin
         sent_count <= sent_count + 1'b1;
      end
   end

   // Read data mux
   always_comb
   begin
      rdata = '0;
      if (sel_ctrl)
      begin
         rdata = {24'h0, ctrl_q.ctrlmode, 2'b00,
                  ctrl_q.ctrlmode_bypass, ctrl_q.tx_enable};
      end
      else if (sel_status)
      begin
         rdata = {16'h0, sent_count};
      end
   end

   // Error on unmapped address or write to status
   assign apb_rsp = '{prdata:  rdata,
                      pready:  1'b1,
                      pslverr: access_phase & (bad_addr | (apb_req.pwrite & sel_status))};

   assign cfg = ctrl_q;

   a_penable_psel: assert property (@(posedge clk) disable iff (!nreset)
      $rose(apb_req.penable) |-> apb_req.psel);

   // Access phase always follows a selected cycle
   a_setup_first: assert property (@(posedge clk) disable iff (!nreset)
      access_phase |-> $past(apb_req.psel));

endmodule

//--- verilog/etx_core.sv
// eMesh transmit core
// Three channel FIFOs (write, read request, read response) feeding
// the priority arbiter, plus the APB register block

module etx_core
   import emesh_pkg::*;
   import etx_cfg_pkg::*;
(
   input  logic        clk,
   input  logic        nreset,
   input  emesh_chan_t txwr_in,
   input  emesh_chan_t txrd_in,
   input  emesh_chan_t txrr_in,
   output logic        txwr_wait,
   output logic        txrd_wait,
   output logic        txrr_wait,
   input  logic        etx_wr_wait,
   input  logic        etx_rd_wait,
   output emesh_chan_t etx_out,
   output logic        etx_rr,
   input  apb_req_t    apb_req,
   output apb_rsp_t    apb_rsp
);

   // FIFO heads and arbiter back-pressure
   emesh_chan_t txwr_head;
   emesh_chan_t txrd_head;
   emesh_chan_t txrr_head;
   logic        txwr_arb_wait;
   logic        txrd_arb_wait;
   logic        txrr_arb_wait;
   etx_cfg_t    cfg;
   logic        etx_sent;

   //####################################################################
   // Channel buffers
   //####################################################################

   etx_fifo u_txwr_fifo (
      .clk      (clk),
      .nreset   (nreset),
      .in       (txwr_in),
      .in_wait  (txwr_wait),
      .out      (txwr_head),
      .out_wait (txwr_arb_wait)
   );

   etx_fifo u_txrd_fifo (
      .clk      (clk),
      .nreset   (nreset),
      .in       (txrd_in),
      .in_wait  (txrd_wait),
      .out      (txrd_head),
      .out_wait (txrd_arb_wait)
   );

   etx_fifo u_txrr_fifo (
      .clk      (clk),
      .nreset   (nreset),
      .in       (txrr_in),
      .in_wait  (txrr_wait),
      .out      (txrr_head),
      .out_wait (txrr_arb_wait)
   );

   //####################################################################
   // Arbitration and registers
   //####################################################################

   etx_arbiter u_arbiter (
      .clk         (clk),
      .nreset      (nreset),
      .txwr        (txwr_head),
      .txrd        (txrd_head),
      .txrr        (txrr_head),
      .txwr_wait   (txwr_arb_wait),
      .txrd_wait   (txrd_arb_wait),
      .txrr_wait   (txrr_arb_wait),
      .cfg         (cfg),
      .etx_wr_wait (etx_wr_wait),
      .etx_rd_wait (etx_rd_wait),
      .etx_out     (etx_out),
      .etx_rr      (etx_rr)
   );

   // Packet leaves when pins take it
   assign etx_sent = etx_out.access & ~etx_wr_wait & ~etx_rd_wait;

   etx_cfg u_cfg (
      .clk      (clk),
      .nreset   (nreset),
      .apb_req  (apb_req),
      .apb_rsp  (apb_rsp),
      .etx_sent (etx_sent),
      .cfg      (cfg)
   );

endmodule

//--- dv/tb_etx_core.sv
// Testbench for the eMesh transmit core
// Reference model of FIFOs, priority pick and output stage, checked by
// concurrent assertions against the pins, the input waits and APB reads

module tb_etx_core
   import emesh_pkg::*;
   import etx_cfg_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CH_WR = 0;
   localparam int CH_RD = 1;
   localparam int CH_RR = 2;
   // Packets per test (APB accesses for the last one)
   localparam int WATCHDOG_CYCLES = 3 + (9 + 12 + 18 + 15 + 8 + 6) * 10;

   logic        clk;
   logic        nreset;
   emesh_chan_t txwr_in;
   emesh_chan_t txrd_in;
   emesh_chan_t txrr_in;
   logic        txwr_wait;
   logic        txrd_wait;
   logic        txrr_wait;
   logic        etx_wr_wait;
   logic        etx_rd_wait;
   emesh_chan_t etx_out;
   logic        etx_rr;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;

   // Reference state
   emesh_packet_t ref_q [3][$];
   logic [2:0]    exp_full;
   // Pushes of the previous edge, not yet at the FIFO heads
   logic [2:0]    last_push;
   logic          exp_access;
   logic          exp_rr;
   emesh_packet_t exp_pkt;
   etx_cfg_t      m_cfg;
   logic [15:0]   m_sent;
   logic [31:0]   exp_rdata;
   logic          exp_err;
   int            err_count;
   int            tests_run;
   int            tests_failed;

   etx_core etx_core_inst (.*);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #10 clk = ~clk;
      end
   end

   //####################################################################
   // Reference model
   //####################################################################

   function automatic emesh_chan_t chan_in(int ch);
      return (ch == CH_WR) ? txwr_in : (ch == CH_RD) ? txrd_in : txrr_in;
   endfunction

   // Host traffic gets reserved cleared and, under bypass, the register ctrlmode
   function automatic emesh_packet_t expected_packet(int ch, emesh_packet_t p, etx_cfg_t c);
      emesh_packet_t e;
      e = p;
      if (ch != CH_RR)
      begin
         e.reserved = 1'b0;
         e.ctrlmode = c.ctrlmode_bypass ? c.ctrlmode : p.ctrlmode;
      end
      return e;
   endfunction

   always @(posedge clk)
   begin
      logic [2:0] push;
      logic       pin_wait;
      int         ch;
      if (!nreset)
      begin
         for (int i = 0; i < 3; i++)
         begin
            ref_q[i].delete();
         end
         exp_full   = '0;
         last_push  = '0;
         exp_access = 1'b0;
         exp_rr     = 1'b0;
         exp_pkt    = '0;
         m_cfg      = '{tx_enable: 1'b1, ctrlmode_bypass: 1'b0, ctrlmode: 4'h0};
         m_sent     = '0;
      end
      else
      begin
         pin_wait = etx_wr_wait | etx_rd_wait;
         // Transfer decided on occupancy before this edge
         for (int i = 0; i < 3; i++)
         begin
            push[i] = chan_in(i).access & ~exp_full[i];
         end
         if (exp_access && !pin_wait)
         begin
            m_sent++;
         end
         // Capture skips the entry pushed at the previous edge
         if (!pin_wait)
         begin
            ch = -1;
            if (m_cfg.tx_enable)
            begin
               for (int i = 2; i >= 0; i--)
               begin
                  if (ref_q[i].size() > int'(last_push[i]))
                  begin
                     ch = i;
                  end
               end
            end
            exp_access = (ch >= 0);
            exp_rr     = (ch == CH_RR);
            if (ch >= 0)
            begin
               exp_pkt = expected_packet(ch, ref_q[ch].pop_front(), m_cfg);
            end
         end
         if (apb_req.psel && apb_req.penable && apb_req.pwrite &&
             apb_req.paddr == ETX_CTRL_ADDR)
         begin
            m_cfg = '{tx_enable: apb_req.pwdata[0], ctrlmode_bypass: apb_req.pwdata[1],
                      ctrlmode: apb_req.pwdata[7:4]};
         end
         for (int i = 0; i < 3; i++)
         begin
            if (push[i])
            begin
               ref_q[i].push_back(chan_in(i).packet);
            end
            exp_full[i] = (ref_q[i].size() == FIFO_DEPTH);
         end
         last_push = push;
      end
   end

   // Register map read data and error
   always_comb
   begin
      exp_rdata = '0;
      exp_err   = 1'b0;
      if (apb_req.paddr == ETX_CTRL_ADDR)
      begin
         exp_rdata = {24'h0, m_cfg.ctrlmode, 2'b00, m_cfg.ctrlmode_bypass, m_cfg.tx_enable};
      end
      else if (apb_req.paddr == ETX_STATUS_ADDR)
      begin
         exp_rdata = {16'h0, m_sent};
         exp_err   = apb_req.pwrite;
      end
      else
      begin
         exp_err = 1'b1;
      end
   end

   //####################################################################
   // Checks
   //####################################################################

   a_access: assert property (@(posedge clk) disable iff (!nreset)
      etx_out.access == exp_access)
      else
      begin
         err_count++;
         $display("CHECK FAILED etx_out.access expected %h got %h",
                  $sampled(exp_access), $sampled(etx_out.access));
      end

   a_packet: assert property (@(posedge clk) disable iff (!nreset)
      etx_out.access |-> etx_out.packet == exp_pkt)
      else
      begin
         err_count++;
         $display("CHECK FAILED etx_out.packet expected %h got %h",
                  $sampled(exp_pkt), $sampled(etx_out.packet));
      end

   a_rr: assert property (@(posedge clk) disable iff (!nreset) etx_rr == exp_rr)
      else
      begin
         err_count++;
         $display("CHECK FAILED etx_rr expected %h got %h", $sampled(exp_rr), $sampled(etx_rr));
      end

   // Input waits track a full FIFO
   a_in_wait: assert property (@(posedge clk) disable iff (!nreset)
      {txrr_wait, txrd_wait, txwr_wait} == exp_full)
      else
      begin
         err_count++;
         $display("CHECK FAILED {txrr_wait,txrd_wait,txwr_wait} expected %h got %h",
                  $sampled(exp_full), $sampled({txrr_wait, txrd_wait, txwr_wait}));
      end

   a_hold: assert property (@(posedge clk) disable iff (!nreset)
      (etx_wr_wait || etx_rd_wait) && etx_out.access |=> $stable(etx_out) && $stable(etx_rr))
      else
      begin
         err_count++;
         $display("Output word changed while the pins were waiting");
      end

   a_prdata: assert property (@(posedge clk) disable iff (!nreset)
      apb_req.psel && apb_req.penable && !apb_req.pwrite |-> apb_rsp.prdata == exp_rdata)
      else
      begin
         err_count++;
         $display("CHECK FAILED prdata expected %h got %h",
                  $sampled(exp_rdata), $sampled(apb_rsp.prdata));
      end

   a_pslverr: assert property (@(posedge clk) disable iff (!nreset)
      apb_req.psel && apb_req.penable |-> apb_rsp.pready && apb_rsp.pslverr == exp_err)
      else
      begin
         err_count++;
         $display("CHECK FAILED pslverr expected %h got %h",
                  $sampled(exp_err), $sampled(apb_rsp.pslverr));
      end

   //####################################################################
   // Stimulus helpers
   //####################################################################

   // Wait n edges, then step to the drive point
   task automatic tick(input int n);
      repeat (n) @(posedge clk);
      #2;
   endtask

   task automatic set_chan(input int ch, input emesh_chan_t c);
      case (ch)
         CH_WR:   txwr_in = c;
         CH_RD:   txrd_in = c;
         default: txrr_in = c;
      endcase
   endtask

   function automatic logic wait_of(int ch);
      return (ch == CH_WR) ? txwr_wait : (ch == CH_RD) ? txrd_wait : txrr_wait;
   endfunction

   // Holds each packet until a transfer edge
   // Wait only moves on clock edges, so it is read at the drive point
   task automatic send_packets(input int ch, input int n);
      emesh_chan_t c;
      logic        taken;
      for (int i = 0; i < n; i++)
      begin
         c.access              = 1'b1;
         c.packet.srcaddr      = $urandom;
         c.packet.data         = $urandom;
         c.packet.dstaddr      = $urandom;
         {c.packet.reserved, c.packet.ctrlmode, c.packet.datamode,
          c.packet.write}      = 8'($urandom);
         set_chan(ch, c);
         taken = 1'b0;
         while (!taken)
         begin
            taken = !wait_of(ch);
            tick(1);
         end
      end
      set_chan(ch, '0);
   endtask

   task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                             input logic [31:0] data);
      apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
      tick(1);
      apb_req.penable = 1'b1;
      tick(1);
      apb_req = '0;
   endtask

   // Until model FIFOs and output stage are empty
   task automatic wait_drain();
      while (ref_q[0].size() + ref_q[1].size() + ref_q[2].size() != 0 || exp_access)
      begin
         tick(1);
      end
      tick(1);
   endtask

   task automatic send_all(input int n);
      fork
         send_packets(CH_WR, n);
         send_packets(CH_RD, n);
         send_packets(CH_RR, n);
      join
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests_run++;
      if (err_count != errs_before)
      begin
         tests_failed++;
         $display("test %-14s failed with %0d errors", name, err_count - errs_before);
      end
      else
      begin
         $display("test %-14s ok", name);
      end
   endtask

   //####################################################################
   // Watchdog and test sequence
   //####################################################################

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout after %0d cycles, traffic did not drain", WATCHDOG_CYCLES);
      $display("** FAIL **");
      $finish;
   end

   initial
   begin
      int errs;
      void'($urandom(32'h3b81));
      nreset       = 1'b0;
      txwr_in      = '0;
      txrd_in      = '0;
      txrr_in      = '0;
      etx_wr_wait  = 1'b0;
      etx_rd_wait  = 1'b0;
      apb_req      = '0;
      err_count    = 0;
      tests_run    = 0;
      tests_failed = 0;
      tick(3);
      nreset = 1'b1;
      tick(1);

      // Load all channels while stopped, then release
      errs = err_count;
      apb_access(1'b1, ETX_CTRL_ADDR, 32'h0);
      send_all(3);
      apb_access(1'b1, ETX_CTRL_ADDR, 32'h1);
      wait_drain();
      end_test("priority", errs);

      errs = err_count;
      apb_access(1'b1, ETX_CTRL_ADDR, 32'ha3);
      send_all(2);
      wait_drain();
      apb_access(1'b1, ETX_CTRL_ADDR, 32'h1);
      send_all(2);
      wait_drain();
      end_test("ctrlmode", errs);

      errs = err_count;
      fork
         send_all(6);
      join_none
      tick(3);
      etx_rd_wait = 1'b1;
      tick(12);
      etx_rd_wait = 1'b0;
      tick(2);
      etx_wr_wait = 1'b1;
      tick(10);
      etx_wr_wait = 1'b0;
      wait fork;
      wait_drain();
      end_test("backpressure", errs);

      errs = err_count;
      fork
         send_all(5);
      join_none
      tick(4);
      apb_access(1'b1, ETX_CTRL_ADDR, 32'h0);
      tick(10);
      apb_access(1'b1, ETX_CTRL_ADDR, 32'h1);
      wait fork;
      wait_drain();
      end_test("tx_enable", errs);

      errs = err_count;
      send_packets(CH_RR, 4);
      fork
         send_packets(CH_WR, 2);
         send_packets(CH_RR, 2);
      join
      wait_drain();
      end_test("rr_flag", errs);

      errs = err_count;
      apb_access(1'b1, ETX_CTRL_ADDR, 32'hc3);
      apb_access(1'b0, ETX_CTRL_ADDR, 32'h0);
      apb_access(1'b0, ETX_STATUS_ADDR, 32'h0);
      apb_access(1'b0, 8'h08, 32'h0);
      apb_access(1'b1, ETX_STATUS_ADDR, 32'h5a5a);
      apb_access(1'b1, ETX_CTRL_ADDR, 32'h1);
      end_test("apb", errs);

      $display("tests run %0d, tests failed %0d, check errors %0d",
               tests_run, tests_failed, err_count);
      if (err_count == 0)
      begin
         $display("** PASS **");
      end
      else
      begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- filelist.f
verilog/emesh_pkg.sv
verilog/etx_cfg_pkg.sv
verilog/etx_fifo.sv
verilog/etx_arbiter.sv
verilog/etx_cfg.sv
verilog/etx_core.sv
dv/tb_etx_core.sv
